// File: rtl/raycast_config.svh
`ifndef RAYCAST_CONFIG_SVH
`define RAYCAST_CONFIG_SVH

// ******************************
// screen and fixed-point format
// ******************************

// columns per frame
`define RC_SCREEN_WIDTH 320
// fraction bits of Q8.8
`define RC_FIX_FRAC 8
// camera_x step per column, about 2/320 in Q8.8 scaled by 256
`define RC_CAM_STEP 410

// ******************************
// buffering and flow control
// ******************************

// result buffer entries, also the sequencer's starting credits
`define RC_FIFO_DEPTH 8
// credits granted by the downstream consumer after reset
`define RC_OUT_CREDITS 4

`endif

// File: rtl/raycast_pkg.sv
package raycast_pkg;

    // signed Q8.8 fixed point
    typedef logic signed [15:0] fix_t;

    // screen column index, 0 to 319
    typedef logic [8:0] column_t;

    // one buffered ray, 43 bits
    typedef struct packed {
        column_t column;
        fix_t    ray_dir_x;
        fix_t    ray_dir_y;
        // set when the ray points toward negative x
        logic    step_x;
        // set when the ray points toward negative y
        logic    step_y;
    } ray_result_t;

endpackage

// File: rtl/ray_job_if.sv
`timescale 1ns/1ps

interface ray_job_if;

    // one cycle pulse per column job
    logic                valid;
    logic [8:0]          column;
    raycast_pkg::fix_t   camera_x;
    // pose copies travel with each job
    raycast_pkg::fix_t   dir_x;
    raycast_pkg::fix_t   dir_y;
    raycast_pkg::fix_t   plane_x;
    raycast_pkg::fix_t   plane_y;

    // sequencer side
    modport sender (
        output valid, column, camera_x, dir_x, dir_y, plane_x, plane_y
    );

    // direction unit side, always accepts
    modport receiver (
        input valid, column, camera_x, dir_x, dir_y, plane_x, plane_y
    );

endinterface

// File: rtl/ray_result_if.sv
`timescale 1ns/1ps

interface ray_result_if;

    // one cycle pulse per finished ray
    logic                  valid;
    raycast_pkg::column_t  column;
    raycast_pkg::fix_t     ray_dir_x;
    raycast_pkg::fix_t     ray_dir_y;
    // sign bits of the ray direction
    logic                  step_x;
    logic                  step_y;

    // direction unit side
    modport sender (
        output valid, column, ray_dir_x, ray_dir_y, step_x, step_y
    );

    // result buffer side, space already reserved by credits
    modport receiver (
        input valid, column, ray_dir_x, ray_dir_y, step_x, step_y
    );

endinterface

// File: rtl/column_sequencer.sv
`timescale 1ns/1ps
`include "raycast_config.svh"

module column_sequencer (
    input  logic               clk_pixel,
    input  logic               sys_rst,
    input  logic               frame_start,
    input  raycast_pkg::fix_t  dir_x,
    input  raycast_pkg::fix_t  dir_y,
    input  raycast_pkg::fix_t  plane_x,
    input  raycast_pkg::fix_t  plane_y,
    input  logic               credit_return,
    output logic               frame_busy,
    ray_job_if.sender          job
);
    import raycast_pkg::*;

    // accumulator holds column * RC_CAM_STEP
    localparam int ACC_W = $clog2(`RC_SCREEN_WIDTH * `RC_CAM_STEP);
    localparam int CRD_W = $clog2(`RC_FIFO_DEPTH + 1);
    localparam column_t LAST_COL = column_t'(`RC_SCREEN_WIDTH - 1);
    // 1.0 in Q8.8
    localparam fix_t ONE_FIX = fix_t'(1 << `RC_FIX_FRAC);

    fix_t              dir_x_q;
    fix_t              dir_y_q;
    fix_t              plane_x_q;
    fix_t              plane_y_q;
    column_t           col_q;
    logic [ACC_W-1:0]  acc_q;
    logic [CRD_W-1:0]  credit_cnt;
    logic              accept;
    logic              issue;

    // frame_start only counts while idle
    assign accept = frame_start && !frame_busy;
    // one job per cycle while a buffer slot is reserved
    assign issue  = frame_busy && (credit_cnt != '0);

    // ******************************
    // pose capture
    // ******************************
    always_ff @(posedge clk_pixel) begin
        if (accept) begin
            dir_x_q   <= dir_x;
            dir_y_q   <= dir_y;
            plane_x_q <= plane_x;
            plane_y_q <= plane_y;
        end
    end

    // ******************************
    // column walk
    // ******************************
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            frame_busy <= 1'b0;
            col_q      <= '0;
            acc_q      <= '0;
        end else if (accept) begin
            frame_busy <= 1'b1;
            col_q      <= '0;
            acc_q      <= '0;
        end else if (issue) begin
            // drop busy right after the last column goes out
            if (col_q == LAST_COL) begin
                frame_busy <= 1'b0;
            end
            col_q <= col_q + 1'b1;
            acc_q <= acc_q + ACC_W'(`RC_CAM_STEP);
        end
    end

    // spend on issue, refill on each buffer read
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            credit_cnt <= CRD_W'(`RC_FIFO_DEPTH);
        end else begin
            credit_cnt <= credit_cnt - CRD_W'(issue) + CRD_W'(credit_return);
        end
    end

    // camera_x = col * step / 256 - 1.0, range about -1 to +1
    assign job.valid    = issue;
    assign job.column   = col_q;
    assign job.camera_x = fix_t'(acc_q >> `RC_FIX_FRAC) - ONE_FIX;
    assign job.dir_x    = dir_x_q;
    assign job.dir_y    = dir_y_q;
    assign job.plane_x  = plane_x_q;
    assign job.plane_y  = plane_y_q;

    // buffer never hands back more slots than it owns
    a_credit_bound: assert property (@(posedge clk_pixel) disable iff (sys_rst)
        credit_cnt <= CRD_W'(`RC_FIFO_DEPTH))
        else $error("internal credit count above buffer depth");

endmodule

// File: rtl/ray_direction_unit.sv
`timescale 1ns/1ps
`include "raycast_config.svh"

module ray_direction_unit (
    input  logic          clk_pixel,
    input  logic          sys_rst,
    ray_job_if.receiver   job,
    ray_result_if.sender  result
);
    import raycast_pkg::*;

    // full Q16.16 products
    logic signed [31:0] prod_x;
    logic signed [31:0] prod_y;

    logic     s1_valid;
    column_t  s1_column;
    fix_t     s1_dir_x;
    fix_t     s1_dir_y;
    fix_t     s1_off_x;
    fix_t     s1_off_y;
    fix_t     sum_x;
    fix_t     sum_y;

    logic     s2_valid;
    column_t  s2_column;
    fix_t     s2_ray_x;
    fix_t     s2_ray_y;
    logic     s2_step_x;
    logic     s2_step_y;

    // ******************************
    // stage 1: plane * camera_x
    // ******************************
    always_comb begin
        prod_x = 32'(job.plane_x) * 32'(job.camera_x);
        prod_y = 32'(job.plane_y) * 32'(job.camera_x);
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= job.valid;
        end
    end

    // back to Q8.8, keep the sign
    always_ff @(posedge clk_pixel) begin
        s1_column <= job.column;
        s1_dir_x  <= job.dir_x;
        s1_dir_y  <= job.dir_y;
        s1_off_x  <= fix_t'(prod_x >>> `RC_FIX_FRAC);
        s1_off_y  <= fix_t'(prod_y >>> `RC_FIX_FRAC);
    end

    // ******************************
    // stage 2: dir + offset, signs
    // ******************************
    // 16-bit sum, wraps on overflow
    assign sum_x = s1_dir_x + s1_off_x;
    assign sum_y = s1_dir_y + s1_off_y;

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk_pixel) begin
        s2_column <= s1_column;
        s2_ray_x  <= sum_x;
        s2_ray_y  <= sum_y;
        // negative direction steps toward -1
        s2_step_x <= sum_x[15];
        s2_step_y <= sum_y[15];
    end

    assign result.valid     = s2_valid;
    assign result.column    = s2_column;
    assign result.ray_dir_x = s2_ray_x;
    assign result.ray_dir_y = s2_ray_y;
    assign result.step_x    = s2_step_x;
    assign result.step_y    = s2_step_y;

endmodule

// File: rtl/ray_result_fifo.sv
`timescale 1ns/1ps
`include "raycast_config.svh"

module ray_result_fifo (
    input  logic                  clk_pixel,
    input  logic                  sys_rst,
    ray_result_if.receiver        result,
    output logic                  credit_return,
    input  logic                  out_credit,
    output logic                  out_valid,
    output raycast_pkg::column_t  out_column,
    output raycast_pkg::fix_t     out_ray_dir_x,
    output raycast_pkg::fix_t     out_ray_dir_y,
    output logic                  out_step_x,
    output logic                  out_step_y
);
    import raycast_pkg::*;

    localparam int DEPTH = `RC_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int OCR_W = $clog2(`RC_OUT_CREDITS + 1);

    ray_result_t       mem [DEPTH];
    ray_result_t       wr_entry;
    ray_result_t       rd_entry;
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [OCR_W-1:0]  out_cred;
    logic              send;

    // pack the incoming ray
    always_comb begin
        wr_entry.column    = result.column;
        wr_entry.ray_dir_x = result.ray_dir_x;
        wr_entry.ray_dir_y = result.ray_dir_y;
        wr_entry.step_x    = result.step_x;
        wr_entry.step_y    = result.step_y;
    end

    assign rd_entry = mem[rd_ptr];
    // need an entry and a downstream credit
    assign send = (count != '0) && (out_cred != '0);

    // ******************************
    // storage
    // ******************************
    always_ff @(posedge clk_pixel) begin
        if (result.valid) begin
            mem[wr_ptr] <= wr_entry;
        end
    end

    // pointers wrap by themselves, depth is a power of two
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (result.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(result.valid) - CNT_W'(send);
        end
    end

    // ******************************
    // output side, credit flow
    // ******************************
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            out_cred      <= OCR_W'(`RC_OUT_CREDITS);
            out_valid     <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            out_cred      <= out_cred - OCR_W'(send) + OCR_W'(out_credit);
            out_valid     <= send;
            // freed slot goes back to the sequencer
            credit_return <= send;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (send) begin
            out_column    <= rd_entry.column;
            out_ray_dir_x <= rd_entry.ray_dir_x;
            out_ray_dir_y <= rd_entry.ray_dir_y;
            out_step_x    <= rd_entry.step_x;
            out_step_y    <= rd_entry.step_y;
        end
    end

    // sequencer credits keep the buffer from overflowing
    a_no_write_full: assert property (@(posedge clk_pixel) disable iff (sys_rst)
        result.valid |-> (count < CNT_W'(DEPTH)))
        else $error("result written into a full buffer");

    // consumer returns at most what it was sent
    a_out_credit_bound: assert property (@(posedge clk_pixel) disable iff (sys_rst)
        out_cred <= OCR_W'(`RC_OUT_CREDITS))
        else $error("output credits above initial grant");

endmodule

// File: rtl/raycast_front_top.sv
`timescale 1ns/1ps

module raycast_front_top (
    input  logic                  clk_pixel,
    input  logic                  sys_rst,
    input  logic                  frame_start,
    input  raycast_pkg::fix_t     dir_x,
    input  raycast_pkg::fix_t     dir_y,
    input  raycast_pkg::fix_t     plane_x,
    input  raycast_pkg::fix_t     plane_y,
    input  logic                  out_credit,
    output logic                  frame_busy,
    output logic                  out_valid,
    output raycast_pkg::column_t  out_column,
    output raycast_pkg::fix_t     out_ray_dir_x,
    output raycast_pkg::fix_t     out_ray_dir_y,
    output logic                  out_step_x,
    output logic                  out_step_y
);
    import raycast_pkg::*;

    // slot freed in the result buffer
    logic credit_return;

    // sequencer to direction unit
    ray_job_if    job_bus ();
    // direction unit to buffer
    ray_result_if result_bus ();

    // ******************************
    // column jobs
    // ******************************
    column_sequencer u_sequencer (
        .clk_pixel     (clk_pixel),
        .sys_rst       (sys_rst),
        .frame_start   (frame_start),
        .dir_x         (dir_x),
        .dir_y         (dir_y),
        .plane_x       (plane_x),
        .plane_y       (plane_y),
        .credit_return (credit_return),
        .frame_busy    (frame_busy),
        .job           (job_bus.sender)
    );

    // two-cycle ray direction pipe
    ray_direction_unit u_direction (
        .clk_pixel (clk_pixel),
        .sys_rst   (sys_rst),
        .job       (job_bus.receiver),
        .result    (result_bus.sender)
    );

    // ******************************
    // buffered output
    // ******************************
    ray_result_fifo u_result_fifo (
        .clk_pixel     (clk_pixel),
        .sys_rst       (sys_rst),
        .result        (result_bus.receiver),
        .credit_return (credit_return),
        .out_credit    (out_credit),
        .out_valid     (out_valid),
        .out_column    (out_column),
        .out_ray_dir_x (out_ray_dir_x),
        .out_ray_dir_y (out_ray_dir_y),
        .out_step_x    (out_step_x),
        .out_step_y    (out_step_y)
    );

endmodule

// File: verif/raycast_front_tb.sv
`timescale 1ns/1ps
`include "raycast_config.svh"

module raycast_front_tb;
    import raycast_pkg::*;

    localparam int MAX_FRAMES    = 16;
    localparam int BUSY_TIMEOUT  = 20000;
    localparam int DRAIN_TIMEOUT = 20000;
    // credits held back once a stall is drawn
    localparam int STALL_CYCLES  = 60;
    localparam int LAST_COL      = `RC_SCREEN_WIDTH - 1;

    logic    clk_pixel;
    logic    sys_rst;
    logic    frame_start;
    fix_t    dir_x;
    fix_t    dir_y;
    fix_t    plane_x;
    fix_t    plane_y;
    logic    out_credit;
    logic    frame_busy;
    logic    out_valid;
    column_t out_column;
    fix_t    out_ray_dir_x;
    fix_t    out_ray_dir_y;
    logic    out_step_x;
    logic    out_step_y;

    // poses and spot values from the vector file
    fix_t v_dir_x [MAX_FRAMES];
    fix_t v_dir_y [MAX_FRAMES];
    fix_t v_plane_x [MAX_FRAMES];
    fix_t v_plane_y [MAX_FRAMES];
    fix_t v_x0 [MAX_FRAMES];
    fix_t v_y0 [MAX_FRAMES];
    fix_t v_x1 [MAX_FRAMES];
    fix_t v_y1 [MAX_FRAMES];
    int   num_frames;

    // accepted frames still owed results in start order
    int          frame_q [$];
    int          next_col;
    int          results_seen;
    int          value_errors;
    int          flow_errors;
    int          timeout_errors;
    // results seen but not yet credited back
    int          outstanding;
    int          stall_cnt;
    logic [31:0] lfsr;
    logic        timed_out;
    // reset as the DUT saw it at the last rising edge
    logic        rst_q;

    raycast_front_top UUT (
        .clk_pixel     (clk_pixel),
        .sys_rst       (sys_rst),
        .frame_start   (frame_start),
        .dir_x         (dir_x),
        .dir_y         (dir_y),
        .plane_x       (plane_x),
        .plane_y       (plane_y),
        .out_credit    (out_credit),
        .frame_busy    (frame_busy),
        .out_valid     (out_valid),
        .out_column    (out_column),
        .out_ray_dir_x (out_ray_dir_x),
        .out_ray_dir_y (out_ray_dir_y),
        .out_step_x    (out_step_x),
        .out_step_y    (out_step_y)
    );

    // 4 ns period
    always #2 clk_pixel = ~clk_pixel;

    always @(posedge clk_pixel) begin
        rst_q <= sys_rst;
    end

    // ******************************
    // compare tasks
    // ******************************
    task automatic check_fix(input string what, input fix_t got, input fix_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_column(input string what, input column_t got, input column_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // ******************************
    // reference model
    // ******************************
    // camera_x = col * step / 256 - 1.0
    function automatic int camera_coord(input int col);
        return ((col * `RC_CAM_STEP) >> `RC_FIX_FRAC) - (1 << `RC_FIX_FRAC);
    endfunction

    // dir + plane * camera_x / 256 wrapped to 16 bits
    function automatic fix_t model_ray(input fix_t d, input fix_t p, input int col);
        int prod;
        int off;
        prod = int'(p) * camera_coord(col);
        off  = prod >>> `RC_FIX_FRAC;
        return fix_t'(int'(d) + off);
    endfunction

    // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_step(lfsr);
        b = lfsr[0];
    endtask

    // ******************************
    // output monitor
    // ******************************
    task automatic check_result();
        int   f;
        fix_t rx;
        fix_t ry;
        if (frame_q.size() == 0) begin
            flow_errors++;
            $display("result for column %0d arrived at %0t with no frame pending",
                     out_column, $time);
        end else begin
            f  = frame_q[0];
            rx = model_ray(v_dir_x[f], v_plane_x[f], next_col);
            ry = model_ray(v_dir_y[f], v_plane_y[f], next_col);
            check_column($sformatf("frame %0d column", f), out_column, column_t'(next_col));
            check_fix($sformatf("frame %0d col %0d ray_dir_x", f, next_col), out_ray_dir_x, rx);
            check_fix($sformatf("frame %0d col %0d ray_dir_y", f, next_col), out_ray_dir_y, ry);
            check_bit($sformatf("frame %0d col %0d step_x", f, next_col), out_step_x, rx < 0);
            check_bit($sformatf("frame %0d col %0d step_y", f, next_col), out_step_y, ry < 0);
            // spot values straight from the file
            if (next_col == 0) begin
                check_fix($sformatf("frame %0d file col 0 x", f), out_ray_dir_x, v_x0[f]);
                check_fix($sformatf("frame %0d file col 0 y", f), out_ray_dir_y, v_y0[f]);
            end
            if (next_col == LAST_COL) begin
                check_fix($sformatf("frame %0d file last x", f), out_ray_dir_x, v_x1[f]);
                check_fix($sformatf("frame %0d file last y", f), out_ray_dir_y, v_y1[f]);
                void'(frame_q.pop_front());
                next_col = 0;
            end else begin
                next_col++;
            end
        end
    endtask

    // random credit return with long holds now and then
    task automatic drive_credit();
        logic       b;
        logic [4:0] pick;
        out_credit = 1'b0;
        if (stall_cnt > 0) begin
            stall_cnt--;
        end else begin
            for (int i = 0; i < 5; i++) begin
                take_bit(b);
                pick[i] = b;
            end
            if (pick == 5'd0) begin
                stall_cnt = STALL_CYCLES;
            end else begin
                take_bit(b);
                if (b && outstanding > 0) begin
                    out_credit = 1'b1;
                    outstanding--;
                end
            end
        end
    endtask

    always @(negedge clk_pixel) begin
        if (rst_q) begin
            out_credit  = 1'b0;
            outstanding = 0;
            stall_cnt   = 0;
        end else begin
            if (out_valid) begin
                results_seen++;
                check_result();
                outstanding++;
                if (outstanding > `RC_OUT_CREDITS) begin
                    flow_errors++;
                    $display("%0d results uncredited at %0t, more than the grant allows",
                             outstanding, $time);
                end
            end
            drive_credit();
        end
    end

    // ******************************
    // stimulus
    // ******************************
    task automatic read_vectors();
        int          fd;
        int          rc;
        string       line;
        logic [15:0] w [8];
        fd = $fopen("verif/ray_vectors.txt", "r");
        if (fd == 0) begin
            flow_errors++;
            $display("could not open verif/ray_vectors.txt");
        end else begin
            while (!$feof(fd) && num_frames < MAX_FRAMES) begin
                line = "";
                rc = $fgets(line, fd);
                // skip comments and blank lines
                if (rc > 0 && line.len() > 1 && line[0] != "#") begin
                    rc = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                 w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]);
                    if (rc == 8) begin
                        v_dir_x[num_frames]   = fix_t'(w[0]);
                        v_dir_y[num_frames]   = fix_t'(w[1]);
                        v_plane_x[num_frames] = fix_t'(w[2]);
                        v_plane_y[num_frames] = fix_t'(w[3]);
                        v_x0[num_frames]      = fix_t'(w[4]);
                        v_y0[num_frames]      = fix_t'(w[5]);
                        v_x1[num_frames]      = fix_t'(w[6]);
                        v_y1[num_frames]      = fix_t'(w[7]);
                        num_frames++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // called on a falling edge while idle
    task automatic start_frame(input int idx);
        dir_x       = v_dir_x[idx];
        dir_y       = v_dir_y[idx];
        plane_x     = v_plane_x[idx];
        plane_y     = v_plane_y[idx];
        frame_start = 1'b1;
        frame_q.push_back(idx);
        @(negedge clk_pixel);
        frame_start = 1'b0;
        check_bit($sformatf("frame_busy after start of frame %0d", idx), frame_busy, 1'b1);
    endtask

    // junk pose that must never reach the output
    task automatic pulse_while_busy();
        if (frame_busy) begin
            dir_x       = 16'sh1234;
            dir_y       = -16'sh0567;
            plane_x     = 16'sh0abc;
            plane_y     = -16'sh0def;
            frame_start = 1'b1;
            @(negedge clk_pixel);
            frame_start = 1'b0;
        end else begin
            flow_errors++;
            $display("frame_busy was already low when a start during a frame was tried");
        end
    endtask

    task automatic wait_busy_low(input int idx);
        int n;
        n = 0;
        while (frame_busy && n < BUSY_TIMEOUT) begin
            @(negedge clk_pixel);
            n++;
        end
        if (frame_busy) begin
            timeout_errors++;
            timed_out = 1'b1;
            $display("timeout: frame_busy stayed high for %0d cycles in frame %0d", n, idx);
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (frame_q.size() != 0 && n < DRAIN_TIMEOUT) begin
            @(negedge clk_pixel);
            n++;
        end
        if (frame_q.size() != 0) begin
            timeout_errors++;
            timed_out = 1'b1;
            $display("timeout: %0d frames still missing results after %0d cycles",
                     frame_q.size(), n);
        end
    endtask

    initial begin
        clk_pixel      = 1'b0;
        sys_rst        = 1'b1;
        frame_start    = 1'b0;
        dir_x          = '0;
        dir_y          = '0;
        plane_x        = '0;
        plane_y        = '0;
        out_credit     = 1'b0;
        num_frames     = 0;
        next_col       = 0;
        results_seen   = 0;
        value_errors   = 0;
        flow_errors    = 0;
        timeout_errors = 0;
        outstanding    = 0;
        stall_cnt      = 0;
        lfsr           = 32'h9487_5f7b;
        timed_out      = 1'b0;
        read_vectors();

        repeat (8) @(negedge clk_pixel);
        sys_rst = 1'b0;
        check_bit("out_valid after reset", out_valid, 1'b0);
        check_bit("frame_busy after reset", frame_busy, 1'b0);
        // idle stretch where the monitor flags any stray result
        repeat (20) @(negedge clk_pixel);

        // back to back frames with one ignored start each
        for (int i = 0; i < num_frames && !timed_out; i++) begin
            start_frame(i);
            repeat (3) @(negedge clk_pixel);
            pulse_while_busy();
            wait_busy_low(i);
        end
        if (!timed_out) begin
            wait_drained();
        end
        // extra columns would show up here
        repeat (40) @(negedge clk_pixel);

        if (num_frames == 0) begin
            flow_errors++;
            $display("no frames were read from the vector file");
        end
        if (!timed_out && results_seen != num_frames * `RC_SCREEN_WIDTH) begin
            flow_errors++;
            $display("saw %0d results, wanted %0d", results_seen,
                     num_frames * `RC_SCREEN_WIDTH);
        end

        $display("errors: value %0d, flow %0d, timeout %0d",
                 value_errors, flow_errors, timeout_errors);
        if (value_errors + flow_errors + timeout_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: verif/ray_vectors.txt
# dir_x dir_y plane_x plane_y ray_x_col0 ray_y_col0 ray_x_col319 ray_y_col319
# signed Q8.8 values in hex, one frame per line
FF00 0000 0000 00A9 FF00 FF57 FF00 00A7
0100 0000 0000 FF57 0100 00A9 0100 FF58
0000 0100 FF57 0000 00A9 0100 FF58 0100
00B5 FF4B 0078 0078 003D FED3 012C FFC2
FF4B FF4B FF88 0078 FFC3 FED3 FED3 FFC2
7F00 0000 0200 0000 7D00 0000 80FC 0000

// File: files.f
+incdir+rtl
rtl/raycast_pkg.sv
rtl/ray_job_if.sv
rtl/ray_result_if.sv
rtl/column_sequencer.sv
rtl/ray_direction_unit.sv
rtl/ray_result_fifo.sv
rtl/raycast_front_top.sv
verif/raycast_front_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module raycast_front_tb -o raycast_front_sim \
    && ./obj_dir/raycast_front_sim 2>&1 | tee sim.log \
    || echo "build or simulation did not complete" >> sim.log
if grep -q "sim failed" sim.log || ! grep -q "sim passed" sim.log; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
